// ==== clock_pkg.sv ====
/*
 * Shared types and limits for the six-digit clock.
 * Field values are plain binary, 0..59 for seconds and minutes, 0..23 for hours.
 * Segment patterns are active high with segment a in the top bit.
 */
package clock_pkg;

	// Field and display widths
	typedef logic [5:0] field_t;
	typedef logic [3:0] digit_t;
	typedef logic [6:0] seg_t;
	typedef logic [5:0] digit_sel_t;

	// Bit 0 seconds, bit 1 minutes, bit 2 hours
	typedef logic [2:0] hms_sel_t;

	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,
		MODE_SETUP = 2'd1,
		MODE_ALARM = 2'd2
	} mode_e;

	typedef enum logic [1:0] {
		POS_SEC = 2'd0,
		POS_MIN = 2'd1,
		POS_HOU = 2'd2
	} pos_e;

	// Wrap limits of the three fields
	localparam int SEC_MAX = 59;
	localparam int MIN_MAX = 59;
	localparam int HOU_MAX = 23;

	localparam int NUM_DIGITS = 6;

endpackage

// ==== digital_clock.sv ====
/*
 * Six-digit clock with setup and alarm, top level.
 * Divider defaults assume a 50 MHz clk. Buttons are active high and need no
 * external synchronizer. The alarm output is a plain level, not a tone.
 */
`timescale 1ns/1ps

module digital_clock #(
	parameter int SEC_DIV  = 50_000_000,
	parameter int SCAN_DIV = 5_000,
	parameter int DEB_DIV  = 500_000
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  i_sw_mode,
	input  logic                  i_sw_pos,
	input  logic                  i_sw_inc,
	input  logic                  i_sw_alarm,
	output clock_pkg::seg_t       o_seg,
	output clock_pkg::digit_sel_t o_seg_enb,
	output logic                  o_seg_dp,
	output logic                  o_alarm
);

	import clock_pkg::*;

	logic     sec_tick;
	logic     scan_tick;
	logic     deb_tick;
	logic     press_mode;
	logic     press_pos;
	logic     press_inc;
	logic     press_alarm;
	logic     alarm_en;
	mode_e    mode;
	pos_e     pos;
	hms_sel_t set_time;
	hms_sel_t set_alarm;
	field_t   disp_sec;
	field_t   disp_min;
	field_t   disp_hou;

	// Tick enables
	tick_gen #(.DIV(SEC_DIV))  u_sec_tick  (.clk(clk), .rst_n(rst_n), .o_tick(sec_tick));
	tick_gen #(.DIV(SCAN_DIV)) u_scan_tick (.clk(clk), .rst_n(rst_n), .o_tick(scan_tick));
	tick_gen #(.DIV(DEB_DIV))  u_deb_tick  (.clk(clk), .rst_n(rst_n), .o_tick(deb_tick));

	key_sync u_key_sync (
		.clk(clk), .rst_n(rst_n), .i_tick(deb_tick),
		.i_sw_mode(i_sw_mode), .i_sw_pos(i_sw_pos),
		.i_sw_inc(i_sw_inc), .i_sw_alarm(i_sw_alarm),
		.o_press_mode(press_mode), .o_press_pos(press_pos),
		.o_press_inc(press_inc), .o_press_alarm(press_alarm));

	mode_ctrl u_mode_ctrl (
		.clk(clk), .rst_n(rst_n),
		.i_press_mode(press_mode), .i_press_pos(press_pos),
		.i_press_inc(press_inc), .i_press_alarm(press_alarm),
		.o_mode(mode), .o_pos(pos), .o_alarm_en(alarm_en),
		.o_set_time(set_time), .o_set_alarm(set_alarm));

	time_core u_time_core (
		.clk(clk), .rst_n(rst_n), .i_sec_tick(sec_tick), .i_mode(mode),
		.i_set_time(set_time), .i_set_alarm(set_alarm), .i_alarm_en(alarm_en),
		.o_disp_sec(disp_sec), .o_disp_min(disp_min), .o_disp_hou(disp_hou),
		.o_alarm(o_alarm));

	seg_scan u_seg_scan (
		.clk(clk), .rst_n(rst_n), .i_scan_tick(scan_tick),
		.i_sec(disp_sec), .i_min(disp_min), .i_hou(disp_hou),
		.i_mode(mode), .i_pos(pos),
		.o_seg(o_seg), .o_seg_enb(o_seg_enb), .o_seg_dp(o_seg_dp));

endmodule

// ==== hms_field.sv ====
/*
 * One wrapping time field, counting 0..MAX.
 * o_wrap is combinational and marks the increment that returns the field to 0.
 * MAX must fit the 6-bit field type.
 */
`timescale 1ns/1ps

module hms_field #(
	parameter int MAX = 59
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              i_inc,
	output clock_pkg::field_t o_value,
	output logic              o_wrap
);

	import clock_pkg::*;

	localparam field_t LAST = field_t'(MAX);

	assign o_wrap = i_inc && (o_value == LAST);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_value <= '0;
		end else if (o_wrap) begin
			o_value <= '0;
		end else if (i_inc) begin
			o_value <= o_value + 1'b1;
		end
	end

	// Field stays within its range
	a_value_range: assert property (@(posedge clk) disable iff (!rst_n)
		o_value <= LAST);

endmodule

// ==== key_sync.sv ====
/*
 * Button sampler with press detection for four active-high buttons.
 * Buttons are sampled only on i_tick, so bounce shorter than one tick period is ignored.
 * A held button gives a single one-cycle pulse.
 */
`timescale 1ns/1ps

module key_sync (
	input  logic clk,
	input  logic rst_n,
	input  logic i_tick,
	input  logic i_sw_mode,
	input  logic i_sw_pos,
	input  logic i_sw_inc,
	input  logic i_sw_alarm,
	output logic o_press_mode,
	output logic o_press_pos,
	output logic o_press_inc,
	output logic o_press_alarm
);

	logic [3:0] sw_raw;
	logic [3:0] samp_new;
	logic [3:0] samp_old;
	logic [3:0] press;

	assign sw_raw = {i_sw_alarm, i_sw_inc, i_sw_pos, i_sw_mode};

	// Two sample stages, the newer one doubles as synchronizer
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			samp_new <= '0;
			samp_old <= '0;
			press    <= '0;
		end else begin
			if (i_tick) begin
				samp_new <= sw_raw;
				samp_old <= samp_new;
			end
			// Rising edge between the two samples
			press <= {4{i_tick}} & samp_new & ~samp_old;
		end
	end

	assign o_press_mode  = press[0];
	assign o_press_pos   = press[1];
	assign o_press_inc   = press[2];
	assign o_press_alarm = press[3];

endmodule

// ==== mode_ctrl.sv ====
/*
 * Mode and field position control.
 * Mode cycles clock, setup, alarm. Position cycles seconds, minutes, hours.
 * Set pulses are combinational from the increment press and last one cycle.
 */
`timescale 1ns/1ps

module mode_ctrl (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                i_press_mode,
	input  logic                i_press_pos,
	input  logic                i_press_inc,
	input  logic                i_press_alarm,
	output clock_pkg::mode_e    o_mode,
	output clock_pkg::pos_e     o_pos,
	output logic                o_alarm_en,
	output clock_pkg::hms_sel_t o_set_time,
	output clock_pkg::hms_sel_t o_set_alarm
);

	import clock_pkg::*;

	mode_e    mode_q;
	pos_e     pos_q;
	hms_sel_t field_sel;

	//--------------------------------------------------
	// State machines
	//--------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mode_q <= MODE_CLOCK;
		end else if (i_press_mode) begin
			case (mode_q)
				MODE_CLOCK: mode_q <= MODE_SETUP;
				MODE_SETUP: mode_q <= MODE_ALARM;
				default:    mode_q <= MODE_CLOCK;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pos_q <= POS_SEC;
		end else if (i_press_pos) begin
			case (pos_q)
				POS_SEC: pos_q <= POS_MIN;
				POS_MIN: pos_q <= POS_HOU;
				default: pos_q <= POS_SEC;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm_en <= 1'b0;
		end else if (i_press_alarm) begin
			o_alarm_en <= ~o_alarm_en;
		end
	end

	assign o_mode = mode_q;
	assign o_pos  = pos_q;

	//--------------------------------------------------
	// Increment routing
	//--------------------------------------------------
	always_comb begin
		case (pos_q)
			POS_SEC: field_sel = 3'b001;
			POS_MIN: field_sel = 3'b010;
			POS_HOU: field_sel = 3'b100;
			default: field_sel = 3'b000;
		endcase
	end

	// Clock mode drops the increment
	always_comb begin
		o_set_time  = '0;
		o_set_alarm = '0;
		if (i_press_inc) begin
			if (mode_q == MODE_SETUP) begin
				o_set_time = field_sel;
			end else if (mode_q == MODE_ALARM) begin
				o_set_alarm = field_sel;
			end
		end
	end

	a_set_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!((|o_set_time) && (|o_set_alarm)));

	a_set_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(o_set_time) && $onehot0(o_set_alarm));

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the clock testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_digital_clock -o tb_sim
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulator returned status $status"
	exit 1
fi

if grep -q "Simulation failed" sim.log; then
	exit 1
fi
exit 0

// ==== seg_scan.sv ====
/*
 * Multiplexed drive of six seven-segment digits.
 * Digit enables are active low, segments and decimal point active high.
 * Digit 0 is seconds ones, digit 5 is hours tens.
 * Decimal points mark the selected field in setup and alarm modes only.
 */
`timescale 1ns/1ps

module seg_scan (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  i_scan_tick,
	input  clock_pkg::field_t     i_sec,
	input  clock_pkg::field_t     i_min,
	input  clock_pkg::field_t     i_hou,
	input  clock_pkg::mode_e      i_mode,
	input  clock_pkg::pos_e       i_pos,
	output clock_pkg::seg_t       o_seg,
	output clock_pkg::digit_sel_t o_seg_enb,
	output logic                  o_seg_dp
);

	import clock_pkg::*;

	localparam int IDX_W = $clog2(NUM_DIGITS);

	logic [IDX_W-1:0] scan_idx;
	logic [1:0]       scan_field;
	digit_t           digits [NUM_DIGITS];
	digit_t           cur_digit;

	function automatic seg_t seg_decode(input digit_t value);
		seg_t seg;
		case (value)
			4'd0:    seg = 7'b111_1110;
			4'd1:    seg = 7'b011_0000;
			4'd2:    seg = 7'b110_1101;
			4'd3:    seg = 7'b111_1001;
			4'd4:    seg = 7'b011_0011;
			4'd5:    seg = 7'b101_1011;
			4'd6:    seg = 7'b101_1111;
			4'd7:    seg = 7'b111_0000;
			4'd8:    seg = 7'b111_1111;
			4'd9:    seg = 7'b111_0011;
			default: seg = 7'b000_0000;
		endcase
		return seg;
	endfunction

	// Tens and ones of each field
	always_comb begin
		digits[0] = digit_t'(i_sec % 6'd10);
		digits[1] = digit_t'(i_sec / 6'd10);
		digits[2] = digit_t'(i_min % 6'd10);
		digits[3] = digit_t'(i_min / 6'd10);
		digits[4] = digit_t'(i_hou % 6'd10);
		digits[5] = digit_t'(i_hou / 6'd10);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scan_idx <= '0;
		end else if (i_scan_tick) begin
			if (scan_idx == IDX_W'(NUM_DIGITS - 1)) begin
				scan_idx <= '0;
			end else begin
				scan_idx <= scan_idx + 1'b1;
			end
		end
	end

	assign cur_digit  = digits[scan_idx];
	assign o_seg      = seg_decode(cur_digit);
	assign o_seg_enb  = ~(digit_sel_t'(1) << scan_idx);

	// Two digits per field, same order as the position codes
	assign scan_field = 2'(scan_idx >> 1);
	assign o_seg_dp   = (i_mode != MODE_CLOCK) && (scan_field == i_pos);

	a_one_digit: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot(~o_seg_enb));

endmodule

// ==== sources.f ====
clock_pkg.sv
tick_gen.sv
key_sync.sv
mode_ctrl.sv
hms_field.sv
time_core.sv
seg_scan.sv
digital_clock.sv
tb_digital_clock.sv

// ==== tb_digital_clock.sv ====
/*
 * Testbench for the six-digit clock with short dividers.
 * A decoder model rebuilds the shown time from the scanned display.
 * A reference model follows the presses and the counted seconds.
 * Presses start 20 cycles into a second and end before the next tick.
 */
`timescale 1ns/1ps

module tb_digital_clock;

	import clock_pkg::*;

	localparam int SEC_DIV    = 64;
	localparam int SCAN_DIV   = 2;
	localparam int DEB_DIV    = 2;
	localparam int HOLD       = 8 * DEB_DIV;
	localparam int TEST_SECS  = 600;
	localparam real TIMEOUT_NS = TEST_SECS * SEC_DIV * 40.0 * 1.2;

	logic       clk;
	logic       rst_n;
	logic       sw_mode;
	logic       sw_pos;
	logic       sw_inc;
	logic       sw_alarm;
	seg_t       seg;
	digit_sel_t seg_enb;
	logic       seg_dp;
	logic       alarm;
	logic       chk;
	logic [15:0] lfsr;
	logic [3:0] dig [NUM_DIGITS];
	logic [5:0] dp_bits;
	logic [5:0] seen;
	logic [7:0] shown [3];
	logic [5:0] exp_dp;
	int         expv [3];
	int         phase;
	int         errors;
	int         test_err;
	int         m_mode;
	int         m_pos;
	int         m_en;
	int         m_alarm;
	int         t [3];
	int         a [3];
	int         n;

	digital_clock #(.SEC_DIV(SEC_DIV), .SCAN_DIV(SCAN_DIV), .DEB_DIV(DEB_DIV)) dut (
		.clk(clk), .rst_n(rst_n), .i_sw_mode(sw_mode), .i_sw_pos(sw_pos),
		.i_sw_inc(sw_inc), .i_sw_alarm(sw_alarm), .o_seg(seg), .o_seg_enb(seg_enb),
		.o_seg_dp(seg_dp), .o_alarm(alarm));

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Reverse segment table with 15 for any unknown pattern
	function automatic logic [3:0] seg_to_digit(input seg_t s);
		case (s)
			7'b111_1110: return 4'd0;
			7'b011_0000: return 4'd1;
			7'b110_1101: return 4'd2;
			7'b111_1001: return 4'd3;
			7'b011_0011: return 4'd4;
			7'b101_1011: return 4'd5;
			7'b101_1111: return 4'd6;
			7'b111_0000: return 4'd7;
			7'b111_1111: return 4'd8;
			7'b111_0011: return 4'd9;
			default:     return 4'd15;
		endcase
	endfunction

	//--------------------------------------------------
	// Display decoder model
	//--------------------------------------------------
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			seen  <= '0;
			phase <= 0;
		end else begin
			phase <= (phase == SEC_DIV - 1) ? 0 : phase + 1;
			// Each check starts a fresh record of enabled digits
			if (chk) begin
				seen <= '0;
			end
			for (int i = 0; i < NUM_DIGITS; i++) begin
				if (!seg_enb[i]) begin
					dig[i]     <= seg_to_digit(seg);
					dp_bits[i] <= seg_dp;
					seen[i]    <= 1'b1;
				end
			end
		end
	end

	always_comb begin
		for (int f = 0; f < 3; f++) begin
			shown[f] = 8'(dig[2*f+1]) * 8'd10 + 8'(dig[2*f]);
			expv[f]  = (m_mode == 2) ? a[f] : t[f];
		end
		exp_dp = (m_mode == 0) ? 6'b0 : (6'b000011 << (2 * m_pos));
	end

	a_sec: assert property (@(posedge clk) chk |-> shown[0] == expv[0]) else begin
		errors++;
		$display("ERR o_seg seconds %h expected %h", shown[0], expv[0]);
	end
	a_min: assert property (@(posedge clk) chk |-> shown[1] == expv[1]) else begin
		errors++;
		$display("ERR o_seg minutes %h expected %h", shown[1], expv[1]);
	end
	a_hou: assert property (@(posedge clk) chk |-> shown[2] == expv[2]) else begin
		errors++;
		$display("ERR o_seg hours %h expected %h", shown[2], expv[2]);
	end
	a_dp: assert property (@(posedge clk) chk |-> dp_bits == exp_dp) else begin
		errors++;
		$display("ERR o_seg_dp mask %h expected %h", dp_bits, exp_dp);
	end
	a_alarm: assert property (@(posedge clk) chk |-> alarm == m_alarm[0]) else begin
		errors++;
		$display("ERR o_alarm %h expected %h", alarm, m_alarm[0]);
	end
	a_scan: assert property (@(posedge clk) chk |-> seen == 6'h3f) else begin
		errors++;
		$display("Not every digit was enabled during the scan");
	end
	a_enb: assert property (@(posedge clk) disable iff (!rst_n) $onehot(~seg_enb)) else begin
		errors++;
		$display("Digit enable does not have exactly one low bit");
	end

	//--------------------------------------------------
	// Reference model and stimulus tasks
	//--------------------------------------------------
	// Fibonacci LFSR stepped once per bit taken
	function automatic int get_rand(input int nbits);
		int val;
		val = 0;
		for (int i = 0; i < nbits; i++) begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			val  = (val << 1) | lfsr[0];
		end
		return val;
	endfunction

	task automatic advance_time();
		t[0] = (t[0] + 1) % 60;
		if (t[0] == 0) t[1] = (t[1] + 1) % 60;
		if (t[0] == 0 && t[1] == 0) t[2] = (t[2] + 1) % 24;
		if (m_en && t[0] == a[0] && t[1] == a[1] && t[2] == a[2]) m_alarm = 1;
	endtask

	// Every wait goes through here so the model sees each second
	task automatic step();
		@(posedge clk);
		if (phase == SEC_DIV - 1 && m_mode != 1) advance_time();
	endtask

	task automatic wait_phase(input int p);
		do step(); while (phase != p);
	endtask

	task automatic press(input int which);
		wait_phase(20);
		case (which)
			0: sw_mode <= 1'b1;
			1: sw_pos <= 1'b1;
			2: sw_inc <= 1'b1;
			default: sw_alarm <= 1'b1;
		endcase
		repeat (HOLD) step();
		sw_mode  <= 1'b0;
		sw_pos   <= 1'b0;
		sw_inc   <= 1'b0;
		sw_alarm <= 1'b0;
		repeat (HOLD) step();
		case (which)
			0: m_mode = (m_mode + 1) % 3;
			1: m_pos = (m_pos + 1) % 3;
			2: begin
				if (m_mode == 1) t[m_pos] = (t[m_pos] + 1) % ((m_pos == 2) ? 24 : 60);
				if (m_mode == 2) a[m_pos] = (a[m_pos] + 1) % ((m_pos == 2) ? 24 : 60);
			end
			default: begin
				m_en = !m_en;
				if (!m_en) m_alarm = 0;
			end
		endcase
	endtask

	task automatic set_field(input int p, input int count);
		while (m_pos != p) press(1);
		repeat (count) press(2);
	endtask

	// One full scan inside a quiet part of the second
	task automatic check();
		wait_phase(20);
		repeat (13) step();
		chk <= 1'b1;
		step();
		chk <= 1'b0;
	endtask

	task automatic run_until_sec(input int s);
		do check(); while (t[0] != s);
	endtask

	task automatic end_test(input string name);
		$display("Test %s: %s (%0d errors)", name, (errors == test_err) ? "pass" : "FAIL",
			errors - test_err);
		test_err = errors;
	endtask

	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog expired before the tests finished");
		$display("Simulation failed");
		$finish;
	end

	initial begin
		rst_n    = 1'b0;
		sw_mode  = 1'b0;
		sw_pos   = 1'b0;
		sw_inc   = 1'b0;
		sw_alarm = 1'b0;
		chk      = 1'b0;
		lfsr     = 16'd29618;
		errors   = 0;
		test_err = 0;
		m_mode   = 0;
		m_pos    = 0;
		m_en     = 0;
		m_alarm  = 0;
		t        = '{0, 0, 0};
		a        = '{0, 0, 0};
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		check();
		end_test("reset state");

		repeat (62) check();
		end_test("clock running");

		press(0);
		for (int p = 0; p < 3; p++) begin
			n = get_rand(5);
			set_field(p, n);
			check();
		end
		end_test("setup mode");

		press(0);
		for (int p = 0; p < 3; p++) begin
			n = get_rand(5);
			set_field(p, n);
			check();
		end
		press(0);
		check();
		end_test("alarm set");

		// Alarm seconds to 40, then time to 35 s before it with the enable off
		press(0);
		press(0);
		set_field(0, (40 - a[0] + 60) % 60);
		press(0);
		press(0);
		set_field(0, (35 - t[0] + 60) % 60);
		set_field(1, (a[1] - t[1] + 60) % 60);
		set_field(2, (a[2] - t[2] + 24) % 24);
		press(0);
		press(0);
		run_until_sec(43);
		press(0);
		set_field(0, (33 - t[0] + 60) % 60);
		press(0);
		press(0);
		press(3);
		run_until_sec(42);
		press(3);
		check();
		end_test("alarm match");

		$display("Checks done with %0d errors", errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== tick_gen.sv ====
/*
 * One-cycle tick enable every DIV clocks.
 * The first tick follows DIV clocks after reset release.
 * DIV of 1 gives a tick on every clock.
 */
`timescale 1ns/1ps

module tick_gen #(
	parameter int DIV = 50_000_000
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_tick
);

	localparam int CW = (DIV > 1) ? $clog2(DIV) : 1;

	logic [CW-1:0] cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt    <= '0;
			o_tick <= 1'b0;
		end else if (cnt == CW'(DIV - 1)) begin
			cnt    <= '0;
			o_tick <= 1'b1;
		end else begin
			cnt    <= cnt + 1'b1;
			o_tick <= 1'b0;
		end
	end

	// Ticks are isolated unless the divider is 1
	if (DIV > 1) begin : g_tick_chk
		a_tick_single: assert property (@(posedge clk) disable iff (!rst_n)
			o_tick |=> !o_tick);
	end

endmodule

// ==== time_core.sv ====
/*
 * Time of day, alarm time and alarm latch.
 * Time runs in clock and alarm modes and holds in setup mode.
 * Setting a field never carries into the next one.
 * The alarm level holds until the enable is cleared.
 */
`timescale 1ns/1ps

module time_core (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                i_sec_tick,
	input  clock_pkg::mode_e    i_mode,
	input  clock_pkg::hms_sel_t i_set_time,
	input  clock_pkg::hms_sel_t i_set_alarm,
	input  logic                i_alarm_en,
	output clock_pkg::field_t   o_disp_sec,
	output clock_pkg::field_t   o_disp_min,
	output clock_pkg::field_t   o_disp_hou,
	output logic                o_alarm
);

	import clock_pkg::*;

	logic     running;
	logic     sec_wrap;
	logic     min_wrap;
	logic     match;
	hms_sel_t time_inc;
	field_t   time_sec;
	field_t   time_min;
	field_t   time_hou;
	field_t   alarm_sec;
	field_t   alarm_min;
	field_t   alarm_hou;

	//--------------------------------------------------
	// Time of day with carry chain
	//--------------------------------------------------
	assign running = (i_mode != MODE_SETUP);

	// Carry only while running, so setup increments stay local
	assign time_inc[0] = (i_sec_tick & running) | i_set_time[0];
	assign time_inc[1] = (sec_wrap & running) | i_set_time[1];
	assign time_inc[2] = (min_wrap & running) | i_set_time[2];

	hms_field #(.MAX(SEC_MAX)) u_time_sec (
		.clk(clk), .rst_n(rst_n), .i_inc(time_inc[0]),
		.o_value(time_sec), .o_wrap(sec_wrap));

	hms_field #(.MAX(MIN_MAX)) u_time_min (
		.clk(clk), .rst_n(rst_n), .i_inc(time_inc[1]),
		.o_value(time_min), .o_wrap(min_wrap));

	hms_field #(.MAX(HOU_MAX)) u_time_hou (
		.clk(clk), .rst_n(rst_n), .i_inc(time_inc[2]),
		.o_value(time_hou), .o_wrap());

	//--------------------------------------------------
	// Alarm time, set only
	//--------------------------------------------------
	hms_field #(.MAX(SEC_MAX)) u_alarm_sec (
		.clk(clk), .rst_n(rst_n), .i_inc(i_set_alarm[0]),
		.o_value(alarm_sec), .o_wrap());

	hms_field #(.MAX(MIN_MAX)) u_alarm_min (
		.clk(clk), .rst_n(rst_n), .i_inc(i_set_alarm[1]),
		.o_value(alarm_min), .o_wrap());

	hms_field #(.MAX(HOU_MAX)) u_alarm_hou (
		.clk(clk), .rst_n(rst_n), .i_inc(i_set_alarm[2]),
		.o_value(alarm_hou), .o_wrap());

	// Display source
	always_comb begin
		if (i_mode == MODE_ALARM) begin
			o_disp_sec = alarm_sec;
			o_disp_min = alarm_min;
			o_disp_hou = alarm_hou;
		end else begin
			o_disp_sec = time_sec;
			o_disp_min = time_min;
			o_disp_hou = time_hou;
		end
	end

	assign match = (time_sec == alarm_sec)
		&& (time_min == alarm_min)
		&& (time_hou == alarm_hou);

	// Set on match, cleared with the enable
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm <= 1'b0;
		end else begin
			o_alarm <= i_alarm_en & (o_alarm | match);
		end
	end

endmodule
